/* bench/tb_led_panel.sv */
`timescale 1ns/100ps
`include "led_matrix_cfg.svh"

module tb_led_panel;

	localparam int BIT_CLKS = `UART_BIT_CLKS;
	localparam int RGB_W = `SEGMENTS * 3;
	localparam int FRAME_BYTES = `ROWS * `COLUMNS * `SEGMENTS * 3;
	// position of the byte with a broken stop bit in the last frame
	localparam int BAD_INDEX = 700;
	localparam int ACK_TIMEOUT = 20000;
	localparam int ROWS_TIMEOUT = 30000;

	logic clk;
	logic rst_n;
	logic uart_rxi;
	logic uart_txo;
	display_pkg::row_t a;
	logic [RGB_W-1:0] rgb;
	logic oclk;
	logic lat;
	logic oe;

	// image being sent and image expected on the panel
	display_pkg::panel_word_t load_frame [`ROWS][`COLUMNS];
	display_pkg::panel_word_t disp_frame [`ROWS][`COLUMNS];
	int display_gen;
	logic suspend;

	logic [RGB_W-1:0] shifted [`COLUMNS];
	int cap_col;
	logic pending;
	display_pkg::row_t prev_a;
	int plane_cnt;
	int en_count;
	int checked_gen;
	int rows_checked;

	led_panel_top led_panel_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.uart_rxi(uart_rxi),
		.uart_txo(uart_txo),
		.a(a),
		.rgb(rgb),
		.oclk(oclk),
		.lat(lat),
		.oe(oe)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_row(input display_pkg::row_t row, input display_pkg::plane_t plane,
		input display_pkg::col_t col, input logic [RGB_W-1:0] got,
		input logic [RGB_W-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail %0t rgb row %0d plane %0d col %0d got %b exp %b",
				$time, row, plane, col, got, exp));
		end
	endtask

	task automatic check_byte(input link_pkg::byte_t got, input link_pkg::byte_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail %0t uart_txo byte got %h exp %h", $time, got, exp));
		end
	endtask

	task automatic check_enable(input int got, input int exp);
		if (got != exp) begin
			abort_run($sformatf("Fail %0t oe low cycles got %0d exp %0d", $time, got, exp));
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail %0t %s got %b exp %b", $time, name, got, exp));
		end
	endtask

	// segment s sits on rgb[3s+2:3s] as blue, green, red
	function automatic logic [RGB_W-1:0] expected_rgb(input display_pkg::row_t row,
		input display_pkg::col_t col, input display_pkg::plane_t plane);
		logic [RGB_W-1:0] bits;
		display_pkg::pixel_t px;
		bits = '0;
		for (int s = 0; s < `SEGMENTS; s++) begin
			px = disp_frame[row][col][s];
			bits[3*s +: 3] = {px.blue[plane], px.green[plane], px.red[plane]};
		end
		return bits;
	endfunction

	task automatic send_byte(input link_pkg::byte_t data, input logic stop_bit);
		logic [9:0] bits;
		bits = {stop_bit, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			uart_rxi <= bits[i];
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
		if (!stop_bit) begin
			// line must go idle again so the next start edge is seen
			@(posedge clk);
			uart_rxi <= 1'b1;
			repeat (2 * BIT_CLKS - 1) @(posedge clk);
		end
	endtask

	task automatic send_frame(input logic add_bad_byte);
		link_pkg::byte_t b;
		int n;
		n = 0;
		for (int r = 0; r < `ROWS; r++) begin
			for (int c = 0; c < `COLUMNS; c++) begin
				for (int s = 0; s < `SEGMENTS; s++) begin
					for (int ch = 0; ch < 3; ch++) begin
						b = link_pkg::byte_t'($urandom);
						case (ch)
							0: load_frame[r][c][s].red = b;
							1: load_frame[r][c][s].green = b;
							default: load_frame[r][c][s].blue = b;
						endcase
						if (add_bad_byte && n == BAD_INDEX) begin
							send_byte(link_pkg::byte_t'($urandom), 1'b0);
						end
						// the flip may follow this byte, the old image goes away
						if (n == FRAME_BYTES - 1) begin
							suspend = 1'b1;
						end
						send_byte(b, 1'b1);
						n++;
					end
				end
			end
		end
	endtask

	task automatic receive_ack(output link_pkg::byte_t data);
		int waited;
		data = '0;
		waited = 0;
		while (uart_txo !== 1'b0) begin
			@(posedge clk);
			waited++;
			if (waited > ACK_TIMEOUT) begin
				abort_run("no acknowledge byte arrived after the frame was sent");
			end
		end
		repeat (BIT_CLKS / 2) @(posedge clk);
		if (uart_txo !== 1'b0) begin
			abort_run("start bit on uart_txo ended before its middle");
		end
		for (int i = 0; i < 8; i++) begin
			repeat (BIT_CLKS) @(posedge clk);
			data[i] = uart_txo;
		end
		repeat (BIT_CLKS) @(posedge clk);
		if (uart_txo !== 1'b1) begin
			abort_run("stop bit of the acknowledge byte is low");
		end
	endtask

	task automatic wait_full_frame();
		int target;
		int waited;
		target = rows_checked + `ROWS * `BITDEPTH;
		waited = 0;
		while (rows_checked < target) begin
			@(posedge clk);
			waited++;
			if (uart_txo !== 1'b1) begin
				abort_run("a second byte appeared on uart_txo after the acknowledge");
			end
			if (waited > ROWS_TIMEOUT) begin
				abort_run("the displayed frame was not scanned in time");
			end
		end
	endtask

	// panel capture, sampled mid-cycle where all outputs are settled
	always @(negedge clk) begin
		if (!rst_n) begin
			cap_col = 0;
			pending = 1'b0;
			prev_a = '0;
			plane_cnt = -1;
			en_count = 0;
			checked_gen = 0;
			rows_checked = 0;
		end else begin
			if (oclk) begin
				if (!oe) begin
					abort_run("oe is active while oclk toggles");
				end
				if (cap_col < `COLUMNS) begin
					shifted[cap_col] = rgb;
				end
				cap_col++;
			end
			if (lat) begin
				if (cap_col != `COLUMNS) begin
					abort_run($sformatf("%0d shift clocks came before a latch", cap_col));
				end
				cap_col = 0;
				pending = 1'b1;
			end else if (pending) begin
				// a has moved to the latched row by the first enable cycle
				pending = 1'b0;
				if (a != prev_a) begin
					plane_cnt = 0;
				end else begin
					plane_cnt++;
				end
				prev_a = a;
				if (plane_cnt >= `BITDEPTH) begin
					abort_run("more bit planes than the colour depth were shown on one row");
				end
				if (a == '0 && plane_cnt == 0) begin
					checked_gen = display_gen;
				end
				if (!suspend && display_gen > 0 && checked_gen == display_gen) begin
					for (int c = 0; c < `COLUMNS; c++) begin
						check_row(a, display_pkg::plane_t'(plane_cnt), display_pkg::col_t'(c),
							shifted[c], expected_rgb(a, display_pkg::col_t'(c),
							display_pkg::plane_t'(plane_cnt)));
					end
					rows_checked++;
				end
			end
			if (!oe) begin
				en_count++;
			end else if (en_count > 0) begin
				check_enable(en_count, `OE_BASE << plane_cnt);
				en_count = 0;
			end
		end
	end

	initial begin
		link_pkg::byte_t ack;
		rst_n = 1'b0;
		uart_rxi = 1'b1;
		suspend = 1'b1;
		display_gen = 0;
		void'($urandom(32'hd5ff_c127));
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_level("lat", lat, 1'b0);
		check_level("oclk", oclk, 1'b0);
		check_level("oe", oe, 1'b1);
		check_level("uart_txo", uart_txo, 1'b1);
		// the third frame carries a byte with a framing error
		for (int f = 0; f < 3; f++) begin
			send_frame(f == 2);
			receive_ack(ack);
			check_byte(ack, link_pkg::FLIP_ACK);
			disp_frame = load_frame;
			display_gen++;
			suspend = 1'b0;
			wait_full_frame();
		end
		$display("all tests passed");
		$finish;
	end

endmodule

/* rtl/display_pkg.sv */
`include "led_matrix_cfg.svh"

package display_pkg;

	// one colour pixel as it sits in the frame memory
	typedef struct packed {
		logic [`BITDEPTH-1:0] red;
		logic [`BITDEPTH-1:0] green;
		logic [`BITDEPTH-1:0] blue;
	} pixel_t;

	// one memory word feeds both segments, index 0 is the upper half
	typedef pixel_t [`SEGMENTS-1:0] panel_word_t;

	// row address within a segment
	typedef logic [$clog2(`ROWS)-1:0] row_t;

	// column position within a row
	typedef logic [$clog2(`COLUMNS)-1:0] col_t;

	// bit plane index for binary-coded modulation
	typedef logic [$clog2(`BITDEPTH)-1:0] plane_t;

endpackage

/* rtl/frame_buffer.sv */
`timescale 1ns/100ps

module frame_buffer (
	input  logic clk,
	input  logic rst_n,
	pixel_wr_if.memory wr,
	input  logic loaded,
	input  logic frame_complete,
	input  display_pkg::row_t rrow,
	input  display_pkg::col_t rcol,
	output display_pkg::panel_word_t rdata,
	output logic ready,
	output logic flipped
);

	// bank bit on top of row and column
	localparam int AW = 1 + $bits(display_pkg::row_t) + $bits(display_pkg::col_t);

	display_pkg::panel_word_t mem [2**AW];
	logic front;
	logic swap;
	logic rbank;
	logic [AW-1:0] waddr;
	logic [AW-1:0] raddr;

	// a full back bank is waiting and the scan has just finished a frame
	assign swap = frame_complete && !ready;

	// the read issued during the swap cycle already sees the new front bank,
	// so the first pixel of the next frame comes from the new image
	assign rbank = front ^ swap;

	assign waddr = {~front, wr.wrow, wr.wcol};
	assign raddr = {rbank, rrow, rcol};

	always_ff @(posedge clk) begin
		if (wr.wen) begin
			mem[waddr] <= wr.wdata;
		end
		rdata <= mem[raddr];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			front <= 1'b0;
			ready <= 1'b1;
			flipped <= 1'b0;
		end else begin
			flipped <= swap;
			if (ready && loaded) begin
				// back bank full, hold it until the next frame boundary
				ready <= 1'b0;
			end else if (swap) begin
				front <= ~front;
				ready <= 1'b1;
			end
		end
	end

	a_flip_after_full: assert property (@(posedge clk) disable iff (!rst_n)
		flipped |-> $past(!ready));

endmodule

/* rtl/led_matrix_cfg.svh */
`ifndef LED_MATRIX_CFG_SVH
`define LED_MATRIX_CFG_SVH

// panel geometry, two halves are scanned in parallel
`define SEGMENTS 2
`define ROWS 8
`define COLUMNS 32

// colour depth per channel, one bit plane per bit
`define BITDEPTH 8

// output enable cycles for bit plane 0, doubles with every plane
`define OE_BASE 1

// clocks per serial bit, kept short for simulation
`define UART_BIT_CLKS 8

`endif

/* rtl/led_panel_top.sv */
`timescale 1ns/100ps
`include "led_matrix_cfg.svh"

module led_panel_top (
	input  logic clk,
	input  logic rst_n,
	input  logic uart_rxi,
	output logic uart_txo,
	output display_pkg::row_t a,
	output logic [`SEGMENTS*3-1:0] rgb,
	output logic oclk,
	output logic lat,
	output logic oe
);

	link_pkg::byte_t rx_data;
	logic rx_valid;
	logic ready;
	logic loaded;
	logic frame_complete;
	logic flipped;
	display_pkg::row_t rrow;
	display_pkg::col_t rcol;
	display_pkg::panel_word_t rdata;

	pixel_wr_if wr_ch ();

	uart_rx uart_rx_inst (
		.clk(clk),
		.rst_n(rst_n),
		.rxi(uart_rxi),
		.data(rx_data),
		.valid(rx_valid)
	);

	pixel_loader pixel_loader_inst (
		.clk(clk),
		.rst_n(rst_n),
		.data(rx_data),
		.valid(rx_valid),
		.ready(ready),
		.wr(wr_ch.loader),
		.loaded(loaded)
	);

	frame_buffer frame_buffer_inst (
		.clk(clk),
		.rst_n(rst_n),
		.wr(wr_ch.memory),
		.loaded(loaded),
		.frame_complete(frame_complete),
		.rrow(rrow),
		.rcol(rcol),
		.rdata(rdata),
		.ready(ready),
		.flipped(flipped)
	);

	scan_driver scan_driver_inst (
		.clk(clk),
		.rst_n(rst_n),
		.rrow(rrow),
		.rcol(rcol),
		.rdata(rdata),
		.frame_complete(frame_complete),
		.a(a),
		.rgb(rgb),
		.oclk(oclk),
		.lat(lat),
		.oe(oe)
	);

	// host learns that its frame is now on display
	uart_tx uart_tx_inst (
		.clk(clk),
		.rst_n(rst_n),
		.start(flipped),
		.txo(uart_txo)
	);

endmodule

/* rtl/link_pkg.sv */
package link_pkg;

	// one serial character
	typedef logic [7:0] byte_t;

	// sent back to the host each time a new frame goes on display
	localparam byte_t FLIP_ACK = 8'he0;

endpackage

/* rtl/pixel_loader.sv */
`timescale 1ns/100ps
`include "led_matrix_cfg.svh"

module pixel_loader (
	input  logic clk,
	input  logic rst_n,
	input  link_pkg::byte_t data,
	input  logic valid,
	input  logic ready,
	pixel_wr_if.loader wr,
	output logic loaded
);

	localparam int SEG_W = (`SEGMENTS > 1) ? $clog2(`SEGMENTS) : 1;

	logic [SEG_W-1:0] seg_cnt;
	logic [1:0] ch_cnt;
	display_pkg::row_t row;
	display_pkg::col_t col;
	display_pkg::panel_word_t word;
	logic take;
	logic word_done;
	logic frame_done;

	// bytes are dropped while the back bank still waits for its flip
	assign take = valid && ready;
	assign word_done = take && (ch_cnt == 2'd2) && (seg_cnt == SEG_W'(`SEGMENTS - 1));
	assign frame_done = (row == display_pkg::row_t'(`ROWS - 1)) &&
		(col == display_pkg::col_t'(`COLUMNS - 1));

	assign wr.wrow = row;
	assign wr.wcol = col;
	assign wr.wdata = word;

	// red, green, blue per segment, upper segment first
	always_ff @(posedge clk) begin
		if (take) begin
			case (ch_cnt)
				2'd0: word[seg_cnt].red <= data;
				2'd1: word[seg_cnt].green <= data;
				default: word[seg_cnt].blue <= data;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			seg_cnt <= '0;
			ch_cnt <= '0;
			row <= '0;
			col <= '0;
			wr.wen <= 1'b0;
			loaded <= 1'b0;
		end else begin
			wr.wen <= word_done;
			loaded <= word_done && frame_done;
			if (take) begin
				if (ch_cnt == 2'd2) begin
					ch_cnt <= '0;
					seg_cnt <= (seg_cnt == SEG_W'(`SEGMENTS - 1)) ? '0 : seg_cnt + 1'b1;
				end else begin
					ch_cnt <= ch_cnt + 1'b1;
				end
			end
			// raster position moves on once the word is written
			if (wr.wen) begin
				if (col == display_pkg::col_t'(`COLUMNS - 1)) begin
					col <= '0;
					row <= (row == display_pkg::row_t'(`ROWS - 1)) ? '0 : row + 1'b1;
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// a write only lands in a back bank that is still being filled
	a_write_open: assert property (@(posedge clk) disable iff (!rst_n)
		wr.wen |-> ready);

endmodule

/* rtl/pixel_wr_if.sv */
`timescale 1ns/100ps

interface pixel_wr_if;

	// one panel word written per cycle while wen is high
	logic wen;
	display_pkg::row_t wrow;
	display_pkg::col_t wcol;
	display_pkg::panel_word_t wdata;

	modport loader (
		output wen,
		output wrow,
		output wcol,
		output wdata
	);

	modport memory (
		input wen,
		input wrow,
		input wcol,
		input wdata
	);

endinterface

/* rtl/scan_driver.sv */
`timescale 1ns/100ps
`include "led_matrix_cfg.svh"

module scan_driver (
	input  logic clk,
	input  logic rst_n,
	output display_pkg::row_t rrow,
	output display_pkg::col_t rcol,
	input  display_pkg::panel_word_t rdata,
	output logic frame_complete,
	output display_pkg::row_t a,
	output logic [`SEGMENTS*3-1:0] rgb,
	output logic oclk,
	output logic lat,
	output logic oe
);

	// longest enable period belongs to the top plane
	localparam int EW = $clog2(`OE_BASE * (1 << (`BITDEPTH - 1)) + 1);
	localparam display_pkg::row_t LAST_ROW = display_pkg::row_t'(`ROWS - 1);
	localparam display_pkg::col_t LAST_COL = display_pkg::col_t'(`COLUMNS - 1);
	localparam display_pkg::plane_t LAST_PLANE = display_pkg::plane_t'(`BITDEPTH - 1);

	typedef enum logic [1:0] {ST_SHIFT, ST_LATCH, ST_DISPLAY} scan_state_t;

	scan_state_t state;
	display_pkg::row_t row;
	display_pkg::row_t nxt_row;
	display_pkg::col_t col;
	display_pkg::col_t col_inc;
	display_pkg::plane_t plane;
	display_pkg::plane_t nxt_plane;
	logic phase;
	logic [EW-1:0] en_cnt;
	logic en_last;

	assign col_inc = (col == LAST_COL) ? '0 : col + 1'b1;
	assign nxt_plane = (plane == LAST_PLANE) ? '0 : plane + 1'b1;
	assign nxt_row = (plane != LAST_PLANE) ? row : ((row == LAST_ROW) ? '0 : row + 1'b1);
	assign en_last = (state == ST_DISPLAY) && (en_cnt == EW'(1));

	// memory reads lead the shift by one cycle; outside the shift the
	// first column of the next plane row is fetched
	assign rrow = (state == ST_SHIFT) ? row : nxt_row;
	assign rcol = (state == ST_SHIFT) ? (phase ? col_inc : col) : '0;

	assign oclk = (state == ST_SHIFT) && phase;
	assign lat = (state == ST_LATCH);
	assign oe = (state != ST_DISPLAY);
	assign frame_complete = en_last && (plane == LAST_PLANE) && (row == LAST_ROW);

	// segment s takes rgb[3s+2:3s]
	always_comb begin
		for (int s = 0; s < `SEGMENTS; s++) begin
			rgb[3*s] = rdata[s].red[plane];
			rgb[3*s+1] = rdata[s].green[plane];
			rgb[3*s+2] = rdata[s].blue[plane];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_SHIFT;
			row <= '0;
			col <= '0;
			plane <= '0;
			phase <= 1'b0;
			en_cnt <= '0;
			a <= '0;
		end else begin
			case (state)
				ST_SHIFT: begin
					phase <= ~phase;
					if (phase) begin
						col <= col_inc;
						if (col == LAST_COL) begin
							// address moves while the outputs are still dark
							a <= row;
							state <= ST_LATCH;
						end
					end
				end
				ST_LATCH: begin
					en_cnt <= EW'(`OE_BASE) << plane;
					state <= ST_DISPLAY;
				end
				default: begin
					en_cnt <= en_cnt - 1'b1;
					if (en_last) begin
						plane <= nxt_plane;
						row <= nxt_row;
						state <= ST_SHIFT;
					end
				end
			endcase
		end
	end

	// row address holds still for the whole lit period
	a_row_held_lit: assert property (@(posedge clk) disable iff (!rst_n) !oe |-> $stable(a));

endmodule

/* rtl/uart_rx.sv */
`timescale 1ns/100ps
`include "led_matrix_cfg.svh"

module uart_rx (
	input  logic clk,
	input  logic rst_n,
	input  logic rxi,
	output link_pkg::byte_t data,
	output logic valid
);

	localparam int BIT_CLKS = `UART_BIT_CLKS;
	localparam int CW = $clog2(BIT_CLKS);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t state;
	logic [1:0] sync;
	logic line_d;
	logic [CW-1:0] cnt;
	logic [2:0] idx;
	link_pkg::byte_t shreg;
	logic sample_bit;

	// lsb arrives first
	assign sample_bit = (state == RX_DATA) && (cnt == '0);
	assign data = shreg;

	always_ff @(posedge clk) begin
		if (sample_bit) begin
			shreg <= {sync[1], shreg[7:1]};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync <= 2'b11;
			line_d <= 1'b1;
			state <= RX_IDLE;
			cnt <= '0;
			idx <= '0;
			valid <= 1'b0;
		end else begin
			sync <= {sync[0], rxi};
			line_d <= sync[1];
			valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					// falling edge starts the half-bit wait
					if (line_d && !sync[1]) begin
						cnt <= CW'(BIT_CLKS / 2 - 1);
						state <= RX_START;
					end
				end
				RX_START: begin
					if (cnt == '0) begin
						// a glitch shorter than half a bit is not a start bit
						if (!sync[1]) begin
							cnt <= CW'(BIT_CLKS - 1);
							idx <= '0;
							state <= RX_DATA;
						end else begin
							state <= RX_IDLE;
						end
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				RX_DATA: begin
					if (cnt == '0) begin
						cnt <= CW'(BIT_CLKS - 1);
						idx <= idx + 1'b1;
						if (idx == 3'd7) begin
							state <= RX_STOP;
						end
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: begin
					// framing error drops the byte
					if (cnt == '0) begin
						valid <= sync[1];
						state <= RX_IDLE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
			endcase
		end
	end

	a_valid_single: assert property (@(posedge clk) disable iff (!rst_n) valid |=> !valid);

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/100ps
`include "led_matrix_cfg.svh"

module uart_tx (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output logic txo
);

	localparam int BIT_CLKS = `UART_BIT_CLKS;
	localparam int CW = $clog2(BIT_CLKS);

	logic busy;
	logic [CW-1:0] cnt;
	logic [3:0] idx;
	// acknowledge byte with the stop bit on top
	logic [8:0] shreg;
	logic bit_end;
	logic launch;

	assign launch = start && !busy;
	assign bit_end = busy && (cnt == '0);

	always_ff @(posedge clk) begin
		if (launch) begin
			shreg <= {1'b1, link_pkg::FLIP_ACK};
		end else if (bit_end) begin
			shreg <= {1'b1, shreg[8:1]};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= '0;
			idx <= '0;
			txo <= 1'b1;
		end else if (launch) begin
			busy <= 1'b1;
			cnt <= CW'(BIT_CLKS - 1);
			idx <= '0;
			txo <= 1'b0;
		end else if (bit_end) begin
			cnt <= CW'(BIT_CLKS - 1);
			if (idx == 4'd9) begin
				// stop bit has run its full time
				busy <= 1'b0;
			end else begin
				txo <= shreg[0];
				idx <= idx + 1'b1;
			end
		end else if (busy) begin
			cnt <= cnt - 1'b1;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -f tb.f --top-module tb_led_panel -o tb_led_panel_sim &&
./obj_dir/tb_led_panel_sim || exit 1

/* tb.f */
+incdir+rtl
rtl/display_pkg.sv
rtl/link_pkg.sv
rtl/pixel_wr_if.sv
rtl/uart_rx.sv
rtl/pixel_loader.sv
rtl/frame_buffer.sv
rtl/scan_driver.sv
rtl/uart_tx.sv
rtl/led_panel_top.sv
bench/tb_led_panel.sv
